//--- sim.f
lsu_pkg.sv
lsu_stage_if.sv
lsu_issue.sv
lsu_bus_master.sv
lsu_load_format.sv
lsu_top.sv
tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - lsu_stage_if.sv
  - lsu_issue.sv
  - lsu_bus_master.sv
  - lsu_load_format.sv
  - lsu_top.sv
  - target: test
    files:
      - tb_lsu.sv

//--- tb_lsu.sv
/*
 * testbench for the load/store unit
 * Wishbone memory model with random wait states, shadow memory,
 * reference load function, result compare process and timeout
 */

`timescale 1ns/1ps

module tb_lsu
    import lsu_pkg::*;
();

    localparam int N_WORDS    = 64;
    localparam int N_RAND     = 200;
    // round trip, extend, sub-word and the two random runs
    localparam int N_REQ      = 32 + 26 + 12 + 2 * N_RAND;
    localparam int MAX_CYCLES = 40 * N_REQ + 100;

    logic        clk = 1'b0;
    logic        reset;
    logic        s_valid;
    logic        s_ready;
    logic        s_rd;
    logic        s_wr;
    rval_t       s_addr;
    size_t       s_size;
    logic        s_unsigned;
    rval_t       s_wdata;
    id_t         s_id;
    ridx_t       s_rd_idx;
    logic        m_valid;
    logic        m_ready;
    id_t         m_id;
    ridx_t       m_rd_idx;
    rval_t       m_rd_val;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [29:0] wb_adr;
    strb_t       wb_sel;
    rval_t       wb_dat_o;
    rval_t       wb_dat_i;
    logic        wb_ack;

    logic [31:0] mem [N_WORDS];
    logic [31:0] shadow [N_WORDS];
    integer      seed      = 57;
    integer      wait_seed = 57;
    integer      bp_seed   = 57;
    int          cycles    = 0;
    int          wait_left;
    int          bp_left;
    logic        bp_on;
    logic        saw_stall;
    logic        hold_pending;
    id_t         held_id;
    rval_t       held_val;
    string       test_name;

    // expected load results in issue order
    id_t         exp_id_q[$];
    ridx_t       exp_ridx_q[$];
    rval_t       exp_val_q[$];
    string       exp_name_q[$];

    lsu_top #(.ADDR_BITS(30)) u_lsu_top (.*);

    always #50 clk = ~clk;

    // ----------------------------------------
    // reference model and checks
    // ----------------------------------------

    function automatic logic [31:0] fill_word(int idx);
        return (idx + 1) * 32'h9e37_79b9;
    endfunction

    function automatic rval_t ref_load(logic [31:0] word, rval_t addr, size_t size, logic uns);
        logic [31:0] part;
        int          sh;
        sh = 8 * addr[1:0];
        case (size)
            SIZE_B: begin
                part = (word >> sh) & 32'h0000_00ff;
                if (!uns && part[7]) part = part | 32'hffff_ff00;
            end
            SIZE_H: begin
                part = (word >> sh) & 32'h0000_ffff;
                if (!uns && part[15]) part = part | 32'hffff_0000;
            end
            default: part = word;
        endcase
        return rval_t'(part);
    endfunction

    task automatic store_shadow(rval_t addr, size_t size, rval_t data);
        int first;
        int count;
        first = addr[1:0];
        count = (size == SIZE_B) ? 1 : (size == SIZE_H) ? 2 : 4;
        for (int k = 0; k < count; k++) begin
            shadow[addr[7:2]][8*(first+k) +: 8] = data[8*k +: 8];
        end
    endtask

    task automatic fail_now(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_rval(string name, rval_t exp, rval_t act);
        if (act !== exp) begin
            fail_now($sformatf("FAIL %s m_rd_val: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_id(string name, id_t exp, id_t act);
        if (act !== exp) begin
            fail_now($sformatf("FAIL %s m_id: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_ridx(string name, ridx_t exp, ridx_t act);
        if (act !== exp) begin
            fail_now($sformatf("FAIL %s m_rd_idx: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_idle(logic in_reset);
        if (m_valid !== 1'b0 || wb_cyc !== 1'b0 || wb_stb !== 1'b0) begin
            fail_now("m_valid, wb_cyc or wb_stb was high around reset");
        end else if (in_reset && s_ready !== 1'b0) begin
            fail_now("s_ready was high during reset");
        end
    endtask

    // ----------------------------------------
    // memory model, result sink, timeout
    // ----------------------------------------

    always @(negedge clk) begin
        if (reset) begin
            wb_ack = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_left == 0) begin
                wb_dat_i = mem[wb_adr[5:0]];
                for (int l = 0; l < 4; l++) begin
                    if (wb_we && wb_sel[l]) mem[wb_adr[5:0]][8*l +: 8] = wb_dat_o[8*l +: 8];
                end
                wb_ack    = 1'b1;
                wait_left = $unsigned($random(wait_seed)) % 4;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // m_ready changes here, so a transfer is known before the edge
    always @(negedge clk) begin
        if (!reset) begin
            if (hold_pending) begin
                if (!m_valid) fail_now("m_valid dropped before write-back took the result");
                check_id({test_name, " hold"}, held_id, m_id);
                check_rval({test_name, " hold"}, held_val, m_rd_val);
            end
            if (!bp_on) begin
                m_ready = 1'b1;
            end else if (bp_left == 0) begin
                m_ready = ~m_ready;
                bp_left = $unsigned($random(bp_seed)) % 12;
            end else begin
                bp_left = bp_left - 1;
            end
            if (m_valid && !m_ready && !s_ready) saw_stall = 1'b1;
            hold_pending = m_valid && !m_ready;
            held_id      = m_id;
            held_val     = m_rd_val;
            if (m_valid && m_ready) begin
                if (exp_val_q.size() == 0) begin
                    fail_now("a result arrived while no load was pending");
                end else begin
                    check_id(exp_name_q[0], exp_id_q.pop_front(), m_id);
                    check_ridx(exp_name_q[0], exp_ridx_q.pop_front(), m_rd_idx);
                    check_rval(exp_name_q.pop_front(), exp_val_q.pop_front(), m_rd_val);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            fail_now($sformatf("timeout, run still going after %0d cycles", cycles));
        end
    end

    // ----------------------------------------
    // request driver
    // ----------------------------------------

    task automatic send(logic wr, rval_t addr, size_t size, logic uns, rval_t wdata,
                        id_t id, ridx_t ridx);
        logic taken;
        s_valid    = 1'b1;
        s_rd       = !wr;
        s_wr       = wr;
        s_addr     = addr;
        s_size     = size;
        s_unsigned = uns;
        s_wdata    = wdata;
        s_id       = id;
        s_rd_idx   = ridx;
        taken      = 1'b0;
        while (!taken) begin
            taken = s_ready;
            if (taken && wr) begin
                store_shadow(addr, size, wdata);
            end else if (taken) begin
                exp_id_q.push_back(id);
                exp_ridx_q.push_back(ridx);
                exp_val_q.push_back(ref_load(shadow[addr[7:2]], addr, size, uns));
                exp_name_q.push_back(test_name);
            end
            @(negedge clk);
        end
        s_valid = 1'b0;
    endtask

    task automatic store(rval_t addr, size_t size, rval_t data);
        send(1'b1, addr, size, 1'b0, data, '0, '0);
    endtask

    task automatic load(rval_t addr, size_t size, logic uns, id_t id, ridx_t ridx);
        send(1'b0, addr, size, uns, '0, id, ridx);
    endtask

    task automatic send_random();
        rval_t addr;
        size_t size;
        rval_t ctl;
        addr = $random(seed);
        size = size_t'($unsigned($random(seed)) % 3);
        ctl  = $random(seed);
        if (size == SIZE_H) addr[0] = 1'b0;
        if (size == SIZE_W) addr[1:0] = 2'b00;
        send(ctl[0], addr, size, ctl[1], $random(seed), ctl[7:4], ctl[12:8]);
    endtask

    task automatic drain();
        while (exp_val_q.size() != 0) @(negedge clk);
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------

    initial begin
        reset      = 1'b1;
        s_valid    = 1'b0;
        s_rd       = 1'b0;
        s_wr       = 1'b0;
        s_addr     = '0;
        s_size     = SIZE_W;
        s_unsigned = 1'b0;
        s_wdata    = '0;
        s_id       = '0;
        s_rd_idx   = '0;
        m_ready    = 1'b1;
        wb_ack     = 1'b0;
        wb_dat_i   = '0;
        bp_on      = 1'b0;
        saw_stall  = 1'b0;
        wait_left  = 0;
        bp_left    = 0;
        hold_pending = 1'b0;
        for (int i = 0; i < N_WORDS; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = fill_word(i);
        end

        test_name = "reset_state";
        repeat (2) begin
            @(negedge clk);
            check_idle(1'b1);
        end
        reset = 1'b0;
        @(negedge clk);
        check_idle(1'b0);

        test_name = "word_round_trip";
        for (int i = 0; i < 16; i++) store(32'h100 + i * 8, SIZE_W, $random(seed));
        for (int i = 0; i < 16; i++) load(32'h100 + i * 8, SIZE_W, 1'b0, id_t'(i), ridx_t'(i + 1));
        drain();

        // bytes 7f, f0, 12, 80 and 9a, 05, c3, 7f
        test_name = "byte_extend";
        store(32'h40, SIZE_W, 32'h8012_f07f);
        store(32'h44, SIZE_W, 32'h7fc3_059a);
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                for (int u = 0; u < 2; u++) begin
                    load(32'h40 + w * 4 + off, SIZE_B, u[0], id_t'(off), ridx_t'(8 * w + off));
                    if (off % 2 == 0) load(32'h40 + w * 4 + off, SIZE_H, u[0], id_t'(u), ridx_t'(w));
                end
            end
        end
        drain();

        test_name = "subword_store";
        for (int off = 0; off < 4; off++) begin
            store(32'h80 + off, SIZE_B, $random(seed));
            load(32'h80, SIZE_W, 1'b0, id_t'(off), ridx_t'(off));
        end
        for (int off = 0; off < 4; off += 2) begin
            store(32'h84 + off, SIZE_H, $random(seed));
            load(32'h84, SIZE_W, 1'b0, id_t'(off), ridx_t'(off + 16));
        end
        drain();

        test_name = "random_order";
        repeat (N_RAND) send_random();
        drain();

        test_name = "back_pressure";
        bp_on = 1'b1;
        repeat (N_RAND) send_random();
        drain();
        bp_on = 1'b0;

        if (!saw_stall) begin
            fail_now("s_ready never fell while m_ready held results back");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- lsu_top.sv
/*
 * load/store unit top level
 * issue, Wishbone classic master and load format stages
 * joined by two valid/ready stage interfaces
 */

`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
#(
    parameter int ADDR_BITS = 30
) (
    input  logic                 clk,
    input  logic                 reset,

    // requests from execute
    input  logic                 s_valid,
    output logic                 s_ready,
    input  logic                 s_rd,
    input  logic                 s_wr,
    input  rval_t                s_addr,
    input  size_t                s_size,
    input  logic                 s_unsigned,
    input  rval_t                s_wdata,
    input  id_t                  s_id,
    input  ridx_t                s_rd_idx,

    // load results to write-back
    output logic                 m_valid,
    input  logic                 m_ready,
    output id_t                  m_id,
    output ridx_t                m_rd_idx,
    output rval_t                m_rd_val,

    // data memory bus
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [ADDR_BITS-1:0] wb_adr,
    output strb_t                wb_sel,
    output rval_t                wb_dat_o,
    input  rval_t                wb_dat_i,
    input  logic                 wb_ack
);

    lsu_stage_if #(.payload_t(bus_cmd_t))  cmd_if ();
    lsu_stage_if #(.payload_t(load_rsp_t)) rsp_if ();

    lsu_issue #(
        .ADDR_BITS (ADDR_BITS)
    ) u_issue (
        .clk        (clk),
        .reset      (reset),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .s_rd       (s_rd),
        .s_wr       (s_wr),
        .s_addr     (s_addr),
        .s_size     (s_size),
        .s_unsigned (s_unsigned),
        .s_wdata    (s_wdata),
        .s_id       (s_id),
        .s_rd_idx   (s_rd_idx),
        .cmd        (cmd_if.producer)
    );

    lsu_bus_master #(
        .ADDR_BITS (ADDR_BITS)
    ) u_bus_master (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd_if.consumer),
        .rsp      (rsp_if.producer),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    lsu_load_format u_load_format (
        .clk      (clk),
        .reset    (reset),
        .rsp      (rsp_if.consumer),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .m_id     (m_id),
        .m_rd_idx (m_rd_idx),
        .m_rd_val (m_rd_val)
    );

endmodule

//--- lsu_load_format.sv
/*
 * load format stage of the load/store unit
 * picks the addressed byte, half or word out of the read word,
 * extends it and holds the result for write-back
 */

`timescale 1ns/1ps

module lsu_load_format
    import lsu_pkg::*;
(
    input  logic          clk,
    input  logic          reset,

    lsu_stage_if.consumer rsp,

    output logic          m_valid,
    input  logic          m_ready,
    output id_t           m_id,
    output ridx_t         m_rd_idx,
    output rval_t         m_rd_val
);

    word_t shifted;
    rval_t rd_val;
    logic  rsp_fire;

    // ----------------------------------------
    // extract and extend
    // ----------------------------------------

    assign shifted = rsp.payload.rdata >> {rsp.payload.align, 3'b000};

    always_comb begin
        case (rsp.payload.size)
            SIZE_B: begin
                if (rsp.payload.is_unsigned) begin
                    rd_val = rval_t'({24'b0, shifted[7:0]});
                end else begin
                    rd_val = rval_t'({{24{shifted[7]}}, shifted[7:0]});
                end
            end
            SIZE_H: begin
                if (rsp.payload.is_unsigned) begin
                    rd_val = rval_t'({16'b0, shifted[15:0]});
                end else begin
                    rd_val = rval_t'({{16{shifted[15]}}, shifted[15:0]});
                end
            end
            // word, nothing to extend
            default: rd_val = rval_t'(shifted);
        endcase
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------

    assign rsp.ready = !m_valid || m_ready;
    assign rsp_fire  = rsp.valid && rsp.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
        end else if (rsp.ready) begin
            m_valid <= rsp.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            m_id     <= rsp.payload.id;
            m_rd_idx <= rsp.payload.rd_idx;
            m_rd_val <= rd_val;
        end
    end

endmodule

//--- lsu_bus_master.sv
/*
 * Wishbone classic master of the load/store unit
 * one bus cycle per command, read word captured for loads
 * and held until the format stage takes it
 */

`timescale 1ns/1ps

module lsu_bus_master
    import lsu_pkg::*;
#(
    parameter int ADDR_BITS = 30
) (
    input  logic                 clk,
    input  logic                 reset,

    lsu_stage_if.consumer        cmd,
    lsu_stage_if.producer        rsp,

    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [ADDR_BITS-1:0] wb_adr,
    output strb_t                wb_sel,
    output rval_t                wb_dat_o,
    input  rval_t                wb_dat_i,
    input  logic                 wb_ack
);

    logic      busy_q;
    logic      rsp_valid_q;
    bus_cmd_t  cmd_q;
    load_rsp_t rsp_q;
    logic      cmd_fire;
    logic      rsp_fire;
    logic      done;

    // a load result still waiting blocks the next command
    assign cmd.ready = !busy_q && !rsp_valid_q;
    assign cmd_fire  = cmd.valid && cmd.ready;
    assign rsp_fire  = rsp_valid_q && rsp.ready;
    assign done      = busy_q && wb_ack;

    // ----------------------------------------
    // control
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            if (cmd_fire) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end

            if (done && !cmd_q.we) begin
                rsp_valid_q <= 1'b1;
            end else if (rsp_fire) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // command latch and read capture
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            cmd_q <= cmd.payload;
        end
        if (done && !cmd_q.we) begin
            rsp_q.rdata       <= wb_dat_i;
            rsp_q.id          <= cmd_q.id;
            rsp_q.rd_idx      <= cmd_q.rd_idx;
            rsp_q.align       <= cmd_q.align;
            rsp_q.size        <= cmd_q.size;
            rsp_q.is_unsigned <= cmd_q.is_unsigned;
        end
    end

    // bus outputs straight from the latch, steady until ack
    assign wb_cyc   = busy_q;
    assign wb_stb   = busy_q;
    assign wb_we    = cmd_q.we;
    assign wb_adr   = cmd_q.adr[ADDR_BITS-1:0];
    assign wb_sel   = cmd_q.sel;
    assign wb_dat_o = cmd_q.wdata;

    assign rsp.valid   = rsp_valid_q;
    assign rsp.payload = rsp_q;

endmodule

//--- lsu_issue.sv
/*
 * issue stage of the load/store unit
 * splits the byte address into word address and lane selects,
 * replicates store data into the lanes, holds one command
 */

`timescale 1ns/1ps

module lsu_issue
    import lsu_pkg::*;
#(
    parameter int ADDR_BITS = 30
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     s_valid,
    output logic     s_ready,
    input  logic     s_rd,
    input  logic     s_wr,
    input  rval_t    s_addr,
    input  size_t    s_size,
    input  logic     s_unsigned,
    input  rval_t    s_wdata,
    input  id_t      s_id,
    input  ridx_t    s_rd_idx,

    lsu_stage_if.producer cmd
);

    logic     run_q;
    logic     cmd_valid_q;
    bus_cmd_t cmd_q;
    bus_cmd_t cmd_d;
    align_t   align;

    assign align = s_addr[ALIGN_BITS-1:0];

    // ----------------------------------------
    // command build
    // ----------------------------------------

    always_comb begin
        cmd_d             = '0;
        cmd_d.adr         = waddr_t'(s_addr[ADDR_BITS+ALIGN_BITS-1:ALIGN_BITS]);
        cmd_d.we          = s_wr;
        cmd_d.id          = s_id;
        cmd_d.rd_idx      = s_rd_idx;
        cmd_d.align       = align;
        cmd_d.size        = s_size;
        cmd_d.is_unsigned = s_unsigned;
        case (s_size)
            SIZE_B: begin
                cmd_d.sel   = strb_t'(4'b0001) << align;
                cmd_d.wdata = {4{s_wdata[7:0]}};
            end
            SIZE_H: begin
                // halves sit on lane 0 or lane 2
                cmd_d.sel   = strb_t'(4'b0011) << {align[1], 1'b0};
                cmd_d.wdata = {2{s_wdata[15:0]}};
            end
            default: begin
                cmd_d.sel   = '1;
                cmd_d.wdata = s_wdata;
            end
        endcase
    end

    // ----------------------------------------
    // command register
    // ----------------------------------------

    // empty slot, or the bus master takes the held one this edge
    assign s_ready = run_q && (!cmd_valid_q || cmd.ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q       <= 1'b0;
            cmd_valid_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (s_ready) begin
                cmd_valid_q <= s_valid && (s_rd || s_wr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_valid && s_ready) begin
            cmd_q <= cmd_d;
        end
    end

    assign cmd.valid   = cmd_valid_q;
    assign cmd.payload = cmd_q;

endmodule

//--- lsu_stage_if.sv
/*
 * valid/ready handshake between two pipeline stages
 * payload type set per instance
 */

`timescale 1ns/1ps

interface lsu_stage_if #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     ready;
    payload_t payload;

    // valid and payload hold until valid and ready meet on an edge
    modport producer (
        output valid,
        output payload,
        input  ready
    );

    modport consumer (
        input  valid,
        input  payload,
        output ready
    );

endinterface

//--- lsu_pkg.sv
/*
 * shared definitions for the load/store unit
 * word and lane widths, access size encoding,
 * issue-to-bus command and bus-to-format response payloads
 */

package lsu_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------

    // extend rules in the format stage assume a 32-bit word
    localparam int XLEN       = 32;
    localparam int STRB_BITS  = XLEN / 8;
    localparam int ALIGN_BITS = $clog2(STRB_BITS);
    localparam int WADDR_BITS = XLEN - ALIGN_BITS;
    localparam int ID_BITS    = 4;
    localparam int RIDX_BITS  = 5;

    typedef logic        [ID_BITS-1:0]    id_t;
    typedef logic        [RIDX_BITS-1:0]  ridx_t;
    typedef logic signed [XLEN-1:0]       rval_t;
    typedef logic        [XLEN-1:0]       word_t;
    typedef logic        [STRB_BITS-1:0]  strb_t;
    typedef logic        [ALIGN_BITS-1:0] align_t;
    typedef logic        [WADDR_BITS-1:0] waddr_t;

    // ----------------------------------------
    // access size
    // ----------------------------------------

    typedef logic [1:0] size_t;

    localparam size_t SIZE_B = 2'b00;
    localparam size_t SIZE_H = 2'b01;
    localparam size_t SIZE_W = 2'b10;

    // ----------------------------------------
    // stage payloads
    // ----------------------------------------

    // one Wishbone access plus the tag of a pending load
    typedef struct packed {
        waddr_t adr;
        logic   we;
        strb_t  sel;
        rval_t  wdata;
        id_t    id;
        ridx_t  rd_idx;
        align_t align;
        size_t  size;
        logic   is_unsigned;
    } bus_cmd_t;

    // raw word as read from the bus, formatting left to the next stage
    typedef struct packed {
        word_t  rdata;
        id_t    id;
        ridx_t  rd_idx;
        align_t align;
        size_t  size;
        logic   is_unsigned;
    } load_rsp_t;

endpackage
